/* common/lane_pkg.sv */
`default_nettype none

package lane_pkg;

   ////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////
   localparam int VRF_DEPTH = 64;
   localparam int MAX_VL    = 32;
   // Write-back register stages before commit
   localparam int WB_DELAY  = 2;

   // Data and addressing
   typedef logic [31:0]                    word_t;
   typedef logic [$clog2(VRF_DEPTH)-1:0]   vaddr_t;
   typedef logic [3:0]                     bwen_t;
   typedef logic [1:0]                     el_sel_t;
   typedef logic [$clog2(MAX_VL)-1:0]      el_idx_t;
   typedef logic [5:0]                     alu_op_t;

   // Element width codes, code 3 is reserved
   typedef logic [1:0] sew_t;
   localparam sew_t SEW_8  = 2'd0;
   localparam sew_t SEW_16 = 2'd1;
   localparam sew_t SEW_32 = 2'd2;

   // Write data source
   typedef logic wr_src_t;
   localparam wr_src_t WR_SRC_ALU  = 1'b0;
   localparam wr_src_t WR_SRC_LOAD = 1'b1;

endpackage

`default_nettype wire

/* common/vrf_wr_if.sv */
`default_nettype none

interface vrf_wr_if;
   import lane_pkg::*;

   // One VRF write port, bytes with a set enable are written
   logic   wen;
   vaddr_t waddr;
   word_t  wdata;
   bwen_t  bwen;

   // Write-back side drives the port
   modport wb (
      output wen,
      output waddr,
      output wdata,
      output bwen
   );

   // Register file side
   modport rf (
      input wen,
      input waddr,
      input wdata,
      input bwen
   );

endinterface

`default_nettype wire

/* design/read_prep.sv */
`default_nettype none

module read_prep (
   input  wire logic               clk_i,
   input  wire logic               rst_i,
   input  wire logic               rd_valid_i,
   input  wire lane_pkg::sew_t     sew_i,
   input  wire lane_pkg::el_sel_t  el_sel_a_i,
   input  wire lane_pkg::el_sel_t  el_sel_b_i,
   input  wire lane_pkg::alu_op_t  op_i,
   input  wire lane_pkg::word_t    rdata_a_i,
   input  wire lane_pkg::word_t    rdata_b_i,
   output lane_pkg::word_t         vs1_o,
   output lane_pkg::word_t         vs2_o,
   output lane_pkg::sew_t          sew_o,
   output lane_pkg::alu_op_t       op_o,
   output logic                    vld_o
);
   import lane_pkg::*;

   // Control aligned with RAM output
   logic    vld_q;
   sew_t    sew_q;
   el_sel_t sel_a_q;
   el_sel_t sel_b_q;
   alu_op_t op_q;

   // Zero-extended element at the selector
   function automatic word_t extract(input word_t data, input el_sel_t sel, input sew_t sew);
      word_t res;
      case (sew)
         SEW_8:   res = {24'd0, data[{sel, 3'b000} +: 8]};
         SEW_16:  res = {16'd0, data[{sel[0], 4'b0000} +: 16]};
         SEW_32:  res = data;
         default: res = '0;
      endcase
      return res;
   endfunction

   ////////////////////////////////////////
   // Stage 1 and operand stage
   ////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         vld_q   <= 1'b0;
         sew_q   <= SEW_8;
         sel_a_q <= '0;
         sel_b_q <= '0;
         op_q    <= '0;
         vld_o   <= 1'b0;
         sew_o   <= SEW_8;
         op_o    <= '0;
         vs1_o   <= '0;
         vs2_o   <= '0;
      end else begin
         vld_q   <= rd_valid_i;
         sew_q   <= sew_i;
         sel_a_q <= el_sel_a_i;
         sel_b_q <= el_sel_b_i;
         op_q    <= op_i;
         vld_o   <= vld_q;
         sew_o   <= sew_q;
         op_o    <= op_q;
         vs1_o   <= extract(rdata_a_i, sel_a_q, sew_q);
         vs2_o   <= extract(rdata_b_i, sel_b_q, sew_q);
      end
   end

endmodule

`default_nettype wire

/* design/vector_lane.sv */
`default_nettype none

module vector_lane (
   input  wire logic               clk_i,
   input  wire logic               rst_i,
   // Read issue
   input  wire lane_pkg::sew_t     vsew_i,
   input  wire logic               rd_valid_i,
   input  wire lane_pkg::vaddr_t   rd_addr_a_i,
   input  wire lane_pkg::vaddr_t   rd_addr_b_i,
   input  wire lane_pkg::el_sel_t  el_sel_a_i,
   input  wire lane_pkg::el_sel_t  el_sel_b_i,
   input  wire lane_pkg::alu_op_t  alu_op_i,
   // Write issue
   input  wire logic               wr_valid_i,
   input  wire lane_pkg::vaddr_t   wr_addr_i,
   input  wire lane_pkg::bwen_t    wr_bwen_i,
   input  wire lane_pkg::wr_src_t  wr_src_i,
   input  wire logic               wr_vm_i,
   input  wire logic               wr_mask_en_i,
   input  wire lane_pkg::el_idx_t  wr_el_i,
   input  wire lane_pkg::word_t    load_data_i,
   // ALU result side
   input  wire logic               alu_vld_i,
   input  wire lane_pkg::word_t    alu_res_i,
   input  wire logic               alu_mask_i,
   // ALU operand side
   output lane_pkg::word_t         vs1_o,
   output lane_pkg::word_t         vs2_o,
   output lane_pkg::alu_op_t       alu_op_o,
   output lane_pkg::sew_t          alu_sew_o,
   output logic                    alu_vld_o
);
   import lane_pkg::*;

   word_t rdata_a;
   word_t rdata_b;

   vrf_wr_if wr_bus ();

   vrf_bank u_vrf (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .raddr_a_i (rd_addr_a_i),
      .raddr_b_i (rd_addr_b_i),
      .rdata_a_o (rdata_a),
      .rdata_b_o (rdata_b),
      .wr        (wr_bus)
   );

   read_prep u_read_prep (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rd_valid_i (rd_valid_i),
      .sew_i      (vsew_i),
      .el_sel_a_i (el_sel_a_i),
      .el_sel_b_i (el_sel_b_i),
      .op_i       (alu_op_i),
      .rdata_a_i  (rdata_a),
      .rdata_b_i  (rdata_b),
      .vs1_o      (vs1_o),
      .vs2_o      (vs2_o),
      .sew_o      (alu_sew_o),
      .op_o       (alu_op_o),
      .vld_o      (alu_vld_o)
   );

   write_back u_write_back (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .wr_valid_i  (wr_valid_i),
      .vm_i        (wr_vm_i),
      .mask_en_i   (wr_mask_en_i),
      .alu_vld_i   (alu_vld_i),
      .alu_mask_i  (alu_mask_i),
      .addr_i      (wr_addr_i),
      .bwen_i      (wr_bwen_i),
      .src_i       (wr_src_i),
      .el_i        (wr_el_i),
      .alu_res_i   (alu_res_i),
      .load_data_i (load_data_i),
      .wr          (wr_bus)
   );

endmodule

`default_nettype wire

/* design/vrf/vrf_bank.sv */
`default_nettype none

module vrf_bank (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire lane_pkg::vaddr_t  raddr_a_i,
   input  wire lane_pkg::vaddr_t  raddr_b_i,
   output lane_pkg::word_t        rdata_a_o,
   output lane_pkg::word_t        rdata_b_o,
   vrf_wr_if.rf                   wr
);
   import lane_pkg::*;

   word_t mem [VRF_DEPTH];

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////
   // Byte lanes written independently
   always_ff @(posedge clk_i) begin
      if (wr.wen) begin
         for (int b = 0; b < 4; b++) begin
            if (wr.bwen[b]) begin
               mem[wr.waddr][b*8 +: 8] <= wr.wdata[b*8 +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////
   // Registered reads, always enabled
   // Same-cycle write to the read address gives old data
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rdata_a_o <= '0;
         rdata_b_o <= '0;
      end else begin
         rdata_a_o <= mem[raddr_a_i];
         rdata_b_o <= mem[raddr_b_i];
      end
   end

endmodule

`default_nettype wire

/* design/write_back.sv */
`default_nettype none

module write_back (
   input  wire logic               clk_i,
   input  wire logic               rst_i,
   input  wire logic               wr_valid_i,
   input  wire logic               vm_i,
   input  wire logic               mask_en_i,
   input  wire logic               alu_vld_i,
   input  wire logic               alu_mask_i,
   input  wire lane_pkg::vaddr_t   addr_i,
   input  wire lane_pkg::bwen_t    bwen_i,
   input  wire lane_pkg::wr_src_t  src_i,
   input  wire lane_pkg::el_idx_t  el_i,
   input  wire lane_pkg::word_t    alu_res_i,
   input  wire lane_pkg::word_t    load_data_i,
   vrf_wr_if.wb                    wr
);
   import lane_pkg::*;

   localparam int LAST = WB_DELAY - 1;

   word_t wdata_sel;
   logic  live;

   // Control chain
   logic [WB_DELAY-1:0] live_q;
   logic [WB_DELAY-1:0] vm_q;
   logic [WB_DELAY-1:0] mask_en_q;

   // Payload chain
   vaddr_t              addr_q  [WB_DELAY];
   word_t               data_q  [WB_DELAY];
   bwen_t               bwen_q  [WB_DELAY];
   el_idx_t             el_q    [WB_DELAY];
   logic [WB_DELAY-1:0] mbit_q;

   // One mask bit per element
   logic [MAX_VL-1:0] vmrf_q;
   logic              mask_bit;

   ////////////////////////////////////////
   // Source select
   ////////////////////////////////////////
   assign wdata_sel = (src_i == WR_SRC_ALU) ? alu_res_i : load_data_i;
   // ALU writes need a valid ALU result
   assign live = wr_valid_i & ((src_i == WR_SRC_LOAD) | alu_vld_i);

   ////////////////////////////////////////
   // Delay chain
   ////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         live_q    <= '0;
         vm_q      <= '0;
         mask_en_q <= '0;
      end else begin
         live_q    <= {live_q[WB_DELAY-2:0], live};
         vm_q      <= {vm_q[WB_DELAY-2:0], vm_i};
         mask_en_q <= {mask_en_q[WB_DELAY-2:0], mask_en_i};
      end
   end

   always_ff @(posedge clk_i) begin
      addr_q[0] <= addr_i;
      data_q[0] <= wdata_sel;
      bwen_q[0] <= bwen_i;
      el_q[0]   <= el_i;
      mbit_q    <= {mbit_q[WB_DELAY-2:0], alu_mask_i};
      for (int i = 1; i < WB_DELAY; i++) begin
         addr_q[i] <= addr_q[i-1];
         data_q[i] <= data_q[i-1];
         bwen_q[i] <= bwen_q[i-1];
         el_q[i]   <= el_q[i-1];
      end
   end

   ////////////////////////////////////////
   // Commit
   ////////////////////////////////////////
   // Mask bit before this cycle's mask write
   assign mask_bit = vmrf_q[el_q[LAST]];

   assign wr.wen   = live_q[LAST];
   assign wr.waddr = addr_q[LAST];
   assign wr.wdata = data_q[LAST];
   assign wr.bwen  = vm_q[LAST] ? (bwen_q[LAST] & {4{mask_bit}}) : bwen_q[LAST];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         vmrf_q <= '0;
      end else if (live_q[LAST] && mask_en_q[LAST]) begin
         vmrf_q[el_q[LAST]] <= mbit_q[LAST];
      end
   end

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // Active-low reset over the first 3 rising edges, released between edges
   initial begin
      rst_o = 1'b0;
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b1;
   end

endmodule

`default_nettype wire

/* dv/tb_vector_lane.sv */
`default_nettype none

module tb_vector_lane;
   timeunit 1ns;
   timeprecision 1ps;
   import lane_pkg::*;

   // Cycle estimate of all tests
   localparam int STIM_CYCLES = 110;
   localparam int WATCHDOG_NS = (STIM_CYCLES + 200) * 20;

   logic    clk_i;
   logic    rst_i;
   logic    rd_valid_i;
   logic    wr_valid_i;
   logic    wr_vm_i;
   logic    wr_mask_en_i;
   logic    alu_vld_i;
   logic    alu_mask_i;
   logic    alu_vld_o;
   sew_t    vsew_i;
   sew_t    alu_sew_o;
   vaddr_t  rd_addr_a_i;
   vaddr_t  rd_addr_b_i;
   vaddr_t  wr_addr_i;
   el_sel_t el_sel_a_i;
   el_sel_t el_sel_b_i;
   alu_op_t alu_op_i;
   alu_op_t alu_op_o;
   bwen_t   wr_bwen_i;
   wr_src_t wr_src_i;
   el_idx_t wr_el_i;
   word_t   load_data_i;
   word_t   alu_res_i;
   word_t   vs1_o;
   word_t   vs2_o;

   // Reference state
   word_t             shadow_vrf [VRF_DEPTH];
   logic [MAX_VL-1:0] shadow_mask;
   // Expected beat is {op, sew, vs1, vs2}
   logic [71:0]       exp_q [$];
   logic [71:0]       exp_head;
   logic              head_missing;
   logic              seen_read;
   logic [31:0]       rng;
   int                timing_errs;
   int                data_errs;

   tb_clkgen u_clkgen (
      .clk_o (clk_i),
      .rst_o (rst_i)
   );

   vector_lane i_dut (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Zero-extended element as the ALU should see it
   function automatic word_t element_of(input word_t w, input el_sel_t sel, input sew_t sew);
      word_t res;
      res = '0;
      if (sew == SEW_8) begin
         res = (w >> (8 * int'(sel))) & 32'h0000_00ff;
      end else if (sew == SEW_16) begin
         res = (w >> (16 * int'(sel[0]))) & 32'h0000_ffff;
      end else if (sew == SEW_32) begin
         res = w;
      end
      return res;
   endfunction

   task automatic idle(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   // One read beat with operands expected from the shadow VRF
   task automatic issue_read(input vaddr_t a, input vaddr_t b, input el_sel_t sa,
                             input el_sel_t sb, input sew_t sew);
      rng = xorshift32(rng);
      rd_valid_i  = 1'b1;
      rd_addr_a_i = a;
      rd_addr_b_i = b;
      el_sel_a_i  = sa;
      el_sel_b_i  = sb;
      vsew_i      = sew;
      alu_op_i    = rng[5:0];
      exp_q.push_back({rng[5:0], sew, element_of(shadow_vrf[a], sa, sew),
                       element_of(shadow_vrf[b], sb, sew)});
      seen_read = 1'b1;
      @(negedge clk_i);
      rd_valid_i = 1'b0;
   endtask

   // One write beat where the unused source carries inverted data
   task automatic issue_write(input vaddr_t addr, input bwen_t be, input wr_src_t src,
                              input logic alu_vld, input logic vm, input logic mask_en,
                              input el_idx_t el, input logic mbit, input word_t data);
      logic  live;
      bwen_t gated;
      live  = (src == WR_SRC_LOAD) || alu_vld;
      gated = (vm && !shadow_mask[el]) ? 4'b0000 : be;
      wr_valid_i   = 1'b1;
      wr_addr_i    = addr;
      wr_bwen_i    = be;
      wr_src_i     = src;
      wr_vm_i      = vm;
      wr_mask_en_i = mask_en;
      wr_el_i      = el;
      alu_vld_i    = alu_vld;
      alu_mask_i   = mbit;
      alu_res_i    = (src == WR_SRC_ALU) ? data : ~data;
      load_data_i  = (src == WR_SRC_LOAD) ? data : ~data;
      if (live) begin
         for (int i = 0; i < 4; i++) begin
            if (gated[i]) begin
               shadow_vrf[addr][8*i +: 8] = data[8*i +: 8];
            end
         end
         // Gating above used the old mask bit
         if (mask_en) begin
            shadow_mask[el] = mbit;
         end
      end
      @(negedge clk_i);
      wr_valid_i = 1'b0;
      alu_vld_i  = 1'b0;
   endtask

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   // Outputs are stable at the falling edge
   always @(negedge clk_i) begin
      if (alu_vld_o) begin
         head_missing = (exp_q.size() == 0);
         if (!head_missing) begin
            exp_head = exp_q.pop_front();
         end
      end
   end

   assert property (@(posedge clk_i) disable iff (!rst_i) alu_vld_o == $past(rd_valid_i, 2))
      else begin
         timing_errs++;
         $display("[FAIL] %0d ns: alu_vld_o is not rd_valid_i delayed by 2 cycles", $time);
      end

   assert property (@(posedge clk_i) disable iff (!rst_i)
                    alu_vld_o |-> !head_missing &&
                                  {alu_op_o, alu_sew_o, vs1_o, vs2_o} == exp_head)
      else begin
         data_errs++;
         $display("[FAIL] %0d ns: got op %h vs1 %h vs2 %h, expected op %h vs1 %h vs2 %h",
                  $time, $sampled(alu_op_o), $sampled(vs1_o), $sampled(vs2_o),
                  exp_head[71:66], exp_head[63:32], exp_head[31:0]);
      end

   // Idle outputs stay zero up to the first read
   assert property (@(posedge clk_i) disable iff (!rst_i)
                    !seen_read |-> !alu_vld_o && vs1_o == '0 && vs2_o == '0)
      else begin
         data_errs++;
         $display("[FAIL] %0d ns: outputs not idle before the first read", $time);
      end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not end within %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   initial begin
      vaddr_t a;
      vaddr_t b;
      rd_valid_i   = 1'b0;
      rd_addr_a_i  = '0;
      rd_addr_b_i  = '0;
      el_sel_a_i   = '0;
      el_sel_b_i   = '0;
      vsew_i       = SEW_32;
      alu_op_i     = '0;
      wr_valid_i   = 1'b0;
      wr_addr_i    = '0;
      wr_bwen_i    = '0;
      wr_src_i     = WR_SRC_LOAD;
      wr_vm_i      = 1'b0;
      wr_mask_en_i = 1'b0;
      wr_el_i      = '0;
      load_data_i  = '0;
      alu_vld_i    = 1'b0;
      alu_res_i    = '0;
      alu_mask_i   = 1'b0;
      rng          = 32'h5ea87b56;
      timing_errs  = 0;
      data_errs    = 0;
      seen_read    = 1'b0;
      head_missing = 1'b0;
      exp_head     = '0;
      shadow_mask  = '0;
      for (int i = 0; i < VRF_DEPTH; i++) begin
         shadow_vrf[i] = '0;
      end
      @(posedge rst_i);
      @(negedge clk_i);
      idle(4);

      // Never-written words read as zero
      issue_read(6'd63, 6'd62, 2'd0, 2'd0, SEW_32);
      idle(3);

      // Random full-word loads read back 3 cycles later
      repeat (8) begin
         rng = xorshift32(rng);
         a = rng[5:0];
         b = rng[13:8];
         rng = xorshift32(rng);
         issue_write(a, 4'hf, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, rng);
         rng = xorshift32(rng);
         issue_write(b, 4'hf, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, rng);
         idle(2);
         issue_read(a, b, 2'd0, 2'd0, SEW_32);
      end

      // Element extraction
      issue_write(6'd5, 4'hf, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'ha1b2_c3d4);
      idle(2);
      for (int s = 0; s < 4; s++) begin
         issue_read(6'd5, 6'd5, el_sel_t'(s), el_sel_t'(3 - s), SEW_8);
      end
      issue_read(6'd5, 6'd5, 2'd0, 2'd1, SEW_16);
      issue_read(6'd5, 6'd5, 2'd1, 2'd0, SEW_16);
      issue_read(6'd5, 6'd5, 2'd2, 2'd3, 2'd3);

      // ALU source needs alu_vld_i
      issue_write(6'd10, 4'hf, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'h1111_1111);
      issue_write(6'd11, 4'hf, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'h2222_2222);
      issue_write(6'd10, 4'hf, WR_SRC_ALU, 1'b1, 1'b0, 1'b0, 5'd0, 1'b0, 32'h3c5a_96e1);
      issue_write(6'd11, 4'hf, WR_SRC_ALU, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'h4d6b_a7f2);
      idle(2);
      issue_read(6'd10, 6'd11, 2'd0, 2'd0, SEW_32);

      // Mask bits, vm gating and partial byte enables
      issue_write(6'd22, 4'hf, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'h1122_3344);
      issue_write(6'd20, 4'h0, WR_SRC_ALU, 1'b1, 1'b0, 1'b1, 5'd3, 1'b1, 32'h0);
      issue_write(6'd20, 4'h0, WR_SRC_ALU, 1'b1, 1'b0, 1'b1, 5'd3, 1'b0, 32'h0);
      issue_write(6'd21, 4'h0, WR_SRC_ALU, 1'b1, 1'b0, 1'b1, 5'd7, 1'b1, 32'h0);
      issue_write(6'd20, 4'hf, WR_SRC_LOAD, 1'b0, 1'b1, 1'b0, 5'd3, 1'b0, 32'hdead_beef);
      issue_write(6'd21, 4'hf, WR_SRC_LOAD, 1'b0, 1'b1, 1'b0, 5'd7, 1'b0, 32'hcafe_f00d);
      issue_write(6'd22, 4'b0101, WR_SRC_LOAD, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'h5566_7788);
      issue_write(6'd21, 4'b1010, WR_SRC_LOAD, 1'b0, 1'b1, 1'b0, 5'd7, 1'b0, 32'h0bad_0bad);
      // Same beat sets the bit but is gated by the old one
      issue_write(6'd23, 4'hf, WR_SRC_ALU, 1'b1, 1'b1, 1'b1, 5'd9, 1'b1, 32'h7777_7777);
      issue_write(6'd23, 4'h3, WR_SRC_ALU, 1'b1, 1'b1, 1'b0, 5'd9, 1'b0, 32'h8888_8888);
      idle(2);
      issue_read(6'd20, 6'd21, 2'd0, 2'd0, SEW_32);
      issue_read(6'd22, 6'd23, 2'd0, 2'd0, SEW_32);

      // Drain the last beats
      for (int i = 0; i < 10 && exp_q.size() != 0; i++) begin
         @(negedge clk_i);
      end
      if (exp_q.size() != 0) begin
         timing_errs++;
         $display("Reads issued but %0d operand beats never came out", exp_q.size());
      end
      idle(2);
      $display("Errors: timing %0d, data %0d", timing_errs, data_errs);
      if (timing_errs == 0 && data_errs == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
common/lane_pkg.sv
common/vrf_wr_if.sv
design/vrf/vrf_bank.sv
design/read_prep.sv
design/write_back.sv
design/vector_lane.sv
dv/tb_clkgen.sv
dv/tb_vector_lane.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector lane testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --x-initial 0 -j 0 \
   --top-module tb_vector_lane -Mdir "$OBJ" -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_vector_lane" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
